//--- design/id_queue_cfg_pkg.sv
// ID queue configuration with fixed sizes, derived index widths and scalar types
package id_queue_cfg_pkg;

    // Width of the ID carried by every element
    localparam int ID_WIDTH = 2;

    // Maximum number of elements stored at once, independent of their ID
    localparam int CAPACITY = 8;

    // Width of the payload word
    localparam int DATA_WIDTH = 16;

    // Number of distinct IDs that can be presented
    localparam int N_IDS = 2 ** ID_WIDTH;

    // One head-tail slot per live ID, and there can never be more live IDs than elements
    localparam int HT_CAPACITY = (N_IDS <= CAPACITY) ? N_IDS : CAPACITY;

    // Index widths for the two tables; a single-entry table still gets one bit
    localparam int HT_IDX_WIDTH = (HT_CAPACITY > 1) ? $clog2(HT_CAPACITY) : 1;
    localparam int LD_IDX_WIDTH = (CAPACITY > 1) ? $clog2(CAPACITY) : 1;

    typedef logic [ID_WIDTH-1:0]     id_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;

    // Index into the head-tail table
    typedef logic [HT_IDX_WIDTH-1:0] ht_idx_t;

    // Index into the linked data table
    typedef logic [LD_IDX_WIDTH-1:0] ld_idx_t;

endpackage

//--- design/id_queue_entry_pkg.sv
// ID queue table entry layouts for the head-tail table and the linked data table
package id_queue_entry_pkg;

    import id_queue_cfg_pkg::*;

    // One subqueue per live ID
    // Head points at the oldest element of the ID and tail at the youngest
    // The free flag marks a slot that holds no ID at all; its other fields are then meaningless
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
        logic    free;
    } head_tail_t;

    // One stored element
    // Next links to the following element of the same ID and is only meaningful
    // when this element is not the tail of its subqueue
    typedef struct packed {
        data_t   data;
        ld_idx_t next;
        logic    free;
    } linked_data_t;

    // Value written into a head-tail slot when its last element is popped
    localparam head_tail_t HT_FREE_ENTRY = '{id: '0, head: '0, tail: '0, free: 1'b1};

    // Reset value of a data entry
    localparam linked_data_t LD_FREE_ENTRY = '{data: '0, next: '0, free: 1'b1};

endpackage

//--- design/id_queue_free_search.sv
// Free-entry search that returns the lowest free index of a table and flags a full table
`timescale 1ns/100ps

module id_queue_free_search #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         free_i,
    output logic [$clog2(WIDTH)-1:0] idx_o,
    output logic                     none_free_o
);

    localparam int IDX_W = $clog2(WIDTH);

    // Priority encoder over the free flags
    // The scan runs from the top down so the lowest set bit is the last one to win
    always_comb begin
        idx_o = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (free_i[i]) begin
                idx_o = IDX_W'(i);
            end
        end
    end

    // With no free bit the index above stays at zero and must not be used
    assign none_free_o = ~|free_i;

endmodule

//--- design/id_queue_ht_table.sv
// ID queue head-tail table holding one subqueue descriptor per live ID with ID lookup
`timescale 1ns/100ps

module id_queue_ht_table
    import id_queue_cfg_pkg::*;
    import id_queue_entry_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    // ID lookup
    input  logic       match_en_i,
    input  id_t        match_id_i,
    output logic       hit_o,
    output ht_idx_t    hit_idx_o,
    output ld_idx_t    hit_head_o,
    output ld_idx_t    hit_tail_o,

    // Lowest slot that does not hold an ID
    output ht_idx_t    free_idx_o,

    // Whole-slot write port
    input  logic       wr_en_i,
    input  ht_idx_t    wr_idx_i,
    input  head_tail_t wr_entry_i
);

    head_tail_t [HT_CAPACITY-1:0] ht_q;

    logic [HT_CAPACITY-1:0] match_oh;
    logic [HT_CAPACITY-1:0] free_vec;

    // Compare the requested ID against every occupied slot
    // An ID lives in at most one slot, so the result is one-hot or zero
    always_comb begin
        for (int i = 0; i < HT_CAPACITY; i++) begin
            match_oh[i] = match_en_i && !ht_q[i].free && (ht_q[i].id == match_id_i);
            free_vec[i] = ht_q[i].free;
        end
    end

    // One-hot to binary by ORing the indices of the set bits
    always_comb begin
        hit_idx_o = '0;
        for (int i = 0; i < HT_CAPACITY; i++) begin
            if (match_oh[i]) begin
                hit_idx_o = hit_idx_o | ht_idx_t'(i);
            end
        end
    end

    assign hit_o = |match_oh;

    // On a miss these point at slot zero; the controller ignores them then
    assign hit_head_o = ht_q[hit_idx_o].head;
    assign hit_tail_o = ht_q[hit_idx_o].tail;

    // A free slot always exists while a data entry is free, since each live ID owns a slot
    id_queue_free_search #(
        .WIDTH       (HT_CAPACITY)
    ) u_free_search (
        .free_i      (free_vec),
        .idx_o       (free_idx_o),
        .none_free_o ()
    );

    // Slot registers, all free out of reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < HT_CAPACITY; i++) begin
                ht_q[i] <= HT_FREE_ENTRY;
            end
        end else if (wr_en_i) begin
            ht_q[wr_idx_i] <= wr_entry_i;
        end
    end

endmodule

//--- design/id_queue_ld_table.sv
// ID queue linked data table holding the elements and the per-ID next links
`timescale 1ns/100ps

module id_queue_ld_table
    import id_queue_cfg_pkg::*;
    import id_queue_entry_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Head read, addressed by the matched head index
    input  ld_idx_t               rd_idx_i,
    output data_t                 rd_data_o,
    output ld_idx_t               rd_next_o,

    // Allocation state
    output ld_idx_t               free_idx_o,
    output logic                  full_o,

    // Occupy an entry with new data
    input  logic                  data_wr_i,
    input  ld_idx_t               data_idx_i,
    input  data_t                 data_i,

    // Append behind an old tail
    input  logic                  link_wr_i,
    input  ld_idx_t               link_idx_i,
    input  ld_idx_t               link_next_i,

    // Give an entry back
    input  logic                  release_i,
    input  ld_idx_t               release_idx_i,

    // Whole-table view for the exists search
    output data_t [CAPACITY-1:0]  data_vec_o,
    output logic  [CAPACITY-1:0]  free_vec_o
);

    linked_data_t [CAPACITY-1:0] ld_q;

    assign rd_data_o = ld_q[rd_idx_i].data;
    assign rd_next_o = ld_q[rd_idx_i].next;

    always_comb begin
        for (int i = 0; i < CAPACITY; i++) begin
            data_vec_o[i] = ld_q[i].data;
            free_vec_o[i] = ld_q[i].free;
        end
    end

    // The queue is full exactly when no data entry is free
    id_queue_free_search #(
        .WIDTH       (CAPACITY)
    ) u_free_search (
        .free_i      (free_vec_o),
        .idx_o       (free_idx_o),
        .none_free_o (full_o)
    );

    // The controller never aims two strobes at the same entry in one cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < CAPACITY; i++) begin
                ld_q[i] <= LD_FREE_ENTRY;
            end
        end else begin
            // A new element is always the tail of its ID, so its next link starts null
            if (data_wr_i) begin
                ld_q[data_idx_i] <= '{data: data_i, next: '0, free: 1'b0};
            end
            if (link_wr_i) begin
                ld_q[link_idx_i].next <= link_next_i;
            end
            if (release_i) begin
                ld_q[release_idx_i].free <= 1'b1;
            end
        end
    end

endmodule

//--- design/id_queue_exists_search.sv
// ID queue exists search comparing a masked word against every occupied element
`timescale 1ns/100ps

module id_queue_exists_search
    import id_queue_cfg_pkg::*;
(
    input  data_t [CAPACITY-1:0] data_vec_i,
    input  logic  [CAPACITY-1:0] free_vec_i,

    input  data_t                exists_data_i,
    input  data_t                exists_mask_i,
    input  logic                 exists_req_i,
    output logic                 exists_o,
    output logic                 exists_gnt_o
);

    // Per-entry match flags
    logic [CAPACITY-1:0] entry_hit;

    // A bit takes part in the comparison only where the mask is set
    // so an all-zero mask matches any occupied entry
    always_comb begin
        for (int i = 0; i < CAPACITY; i++) begin
            entry_hit[i] = !free_vec_i[i] &&
                           (((data_vec_i[i] ^ exists_data_i) & exists_mask_i) == '0);
        end
    end

    // The search never stalls, so the grant just follows the request
    assign exists_gnt_o = exists_req_i;

    // Without a request the result stays low
    assign exists_o = exists_req_i && (|entry_hit);

endmodule

//--- design/id_queue_ctrl.sv
// ID queue controller arbitrating push against read or pop and issuing table updates
`timescale 1ns/100ps

module id_queue_ctrl
    import id_queue_cfg_pkg::*;
    import id_queue_entry_pkg::*;
(
    // Input port
    input  logic       inp_req_i,
    input  id_t        inp_id_i,
    input  data_t      inp_data_i,
    output logic       inp_gnt_o,

    // Output port
    input  logic       oup_req_i,
    input  id_t        oup_id_i,
    input  logic       oup_pop_i,
    output logic       oup_gnt_o,
    output data_t      oup_data_o,
    output logic       oup_data_valid_o,

    // Head-tail table lookup
    output logic       match_en_o,
    output id_t        match_id_o,
    input  logic       hit_i,
    input  ht_idx_t    hit_idx_i,
    input  ld_idx_t    hit_head_i,
    input  ld_idx_t    hit_tail_i,
    input  ht_idx_t    ht_free_idx_i,

    // Head-tail table write
    output logic       ht_wr_o,
    output ht_idx_t    ht_wr_idx_o,
    output head_tail_t ht_wr_entry_o,

    // Linked data table, head read already addressed by the matched head
    input  data_t      rd_data_i,
    input  ld_idx_t    rd_next_i,
    input  ld_idx_t    ld_free_idx_i,
    input  logic       full_i,

    // Linked data table writes
    output logic       data_wr_o,
    output ld_idx_t    data_idx_o,
    output data_t      data_o,
    output logic       link_wr_o,
    output ld_idx_t    link_idx_o,
    output ld_idx_t    link_next_o,
    output logic       release_o,
    output ld_idx_t    release_idx_o
);

    logic push;

    // Input is ready whenever a data entry is free, whether or not it requests
    assign inp_gnt_o = !full_i;
    assign push      = inp_req_i && !full_i;

    always_comb begin
        match_en_o       = 1'b0;
        match_id_o       = '0;
        oup_gnt_o        = 1'b0;
        oup_data_o       = '0;
        oup_data_valid_o = 1'b0;
        ht_wr_o          = 1'b0;
        ht_wr_idx_o      = '0;
        ht_wr_entry_o    = HT_FREE_ENTRY;
        data_wr_o        = 1'b0;
        data_idx_o       = '0;
        data_o           = '0;
        link_wr_o        = 1'b0;
        link_idx_o       = '0;
        link_next_o      = '0;
        release_o        = 1'b0;
        release_idx_o    = '0;

        if (push) begin
            // Input has priority and starves the output this cycle
            match_en_o = 1'b1;
            match_id_o = inp_id_i;
            data_wr_o  = 1'b1;
            data_idx_o = ld_free_idx_i;
            data_o     = inp_data_i;
            ht_wr_o    = 1'b1;
            if (!hit_i) begin
                // First element of this ID opens a fresh slot
                ht_wr_idx_o   = ht_free_idx_i;
                ht_wr_entry_o = '{id: inp_id_i, head: ld_free_idx_i,
                                  tail: ld_free_idx_i, free: 1'b0};
            end else begin
                // Hang the new entry behind the old tail and move the tail
                link_wr_o     = 1'b1;
                link_idx_o    = hit_tail_i;
                link_next_o   = ld_free_idx_i;
                ht_wr_idx_o   = hit_idx_i;
                ht_wr_entry_o = '{id: inp_id_i, head: hit_head_i,
                                  tail: ld_free_idx_i, free: 1'b0};
            end
        end else if (oup_req_i) begin
            // The output is always granted; a miss shows up as invalid zero data
            match_en_o = 1'b1;
            match_id_o = oup_id_i;
            oup_gnt_o  = 1'b1;
            if (hit_i) begin
                oup_data_o       = rd_data_i;
                oup_data_valid_o = 1'b1;
                if (oup_pop_i) begin
                    release_o     = 1'b1;
                    release_idx_o = hit_head_i;
                    ht_wr_o       = 1'b1;
                    ht_wr_idx_o   = hit_idx_i;
                    // Popping the last element of an ID retires its slot
                    if (hit_head_i == hit_tail_i) begin
                        ht_wr_entry_o = HT_FREE_ENTRY;
                    end else begin
                        ht_wr_entry_o = '{id: oup_id_i, head: rd_next_i,
                                          tail: hit_tail_i, free: 1'b0};
                    end
                end
            end
        end
    end

endmodule

//--- design/id_queue_top.sv
// ID queue top level joining controller, head-tail table, data table and exists search
`timescale 1ns/100ps

module id_queue_top
    import id_queue_cfg_pkg::*;
    import id_queue_entry_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  inp_req_i,
    input  id_t   inp_id_i,
    input  data_t inp_data_i,
    output logic  inp_gnt_o,

    input  logic  oup_req_i,
    input  id_t   oup_id_i,
    input  logic  oup_pop_i,
    output logic  oup_gnt_o,
    output data_t oup_data_o,
    output logic  oup_data_valid_o,

    input  logic  exists_req_i,
    input  data_t exists_data_i,
    input  data_t exists_mask_i,
    output logic  exists_o,
    output logic  exists_gnt_o
);

    // Lookup between controller and head-tail table
    logic       match_en;
    id_t        match_id;
    logic       hit;
    ht_idx_t    hit_idx;
    ld_idx_t    hit_head;
    ld_idx_t    hit_tail;
    ht_idx_t    ht_free_idx;

    // Head-tail write
    logic       ht_wr;
    ht_idx_t    ht_wr_idx;
    head_tail_t ht_wr_entry;

    // Linked data read and allocation
    data_t      rd_data;
    ld_idx_t    rd_next;
    ld_idx_t    ld_free_idx;
    logic       full;

    // Linked data writes
    logic       data_wr;
    ld_idx_t    data_idx;
    data_t      wr_data;
    logic       link_wr;
    ld_idx_t    link_idx;
    ld_idx_t    link_next;
    logic       release_en;
    ld_idx_t    release_idx;

    // Table view for the exists search
    data_t [CAPACITY-1:0] data_vec;
    logic  [CAPACITY-1:0] free_vec;

    id_queue_ctrl u_ctrl (
        .inp_req_i        (inp_req_i),
        .inp_id_i         (inp_id_i),
        .inp_data_i       (inp_data_i),
        .inp_gnt_o        (inp_gnt_o),
        .oup_req_i        (oup_req_i),
        .oup_id_i         (oup_id_i),
        .oup_pop_i        (oup_pop_i),
        .oup_gnt_o        (oup_gnt_o),
        .oup_data_o       (oup_data_o),
        .oup_data_valid_o (oup_data_valid_o),
        .match_en_o       (match_en),
        .match_id_o       (match_id),
        .hit_i            (hit),
        .hit_idx_i        (hit_idx),
        .hit_head_i       (hit_head),
        .hit_tail_i       (hit_tail),
        .ht_free_idx_i    (ht_free_idx),
        .ht_wr_o          (ht_wr),
        .ht_wr_idx_o      (ht_wr_idx),
        .ht_wr_entry_o    (ht_wr_entry),
        .rd_data_i        (rd_data),
        .rd_next_i        (rd_next),
        .ld_free_idx_i    (ld_free_idx),
        .full_i           (full),
        .data_wr_o        (data_wr),
        .data_idx_o       (data_idx),
        .data_o           (wr_data),
        .link_wr_o        (link_wr),
        .link_idx_o       (link_idx),
        .link_next_o      (link_next),
        .release_o        (release_en),
        .release_idx_o    (release_idx)
    );

    id_queue_ht_table u_ht_table (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .match_en_i (match_en),
        .match_id_i (match_id),
        .hit_o      (hit),
        .hit_idx_o  (hit_idx),
        .hit_head_o (hit_head),
        .hit_tail_o (hit_tail),
        .free_idx_o (ht_free_idx),
        .wr_en_i    (ht_wr),
        .wr_idx_i   (ht_wr_idx),
        .wr_entry_i (ht_wr_entry)
    );

    // The matched head addresses the data table directly
    id_queue_ld_table u_ld_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .rd_idx_i      (hit_head),
        .rd_data_o     (rd_data),
        .rd_next_o     (rd_next),
        .free_idx_o    (ld_free_idx),
        .full_o        (full),
        .data_wr_i     (data_wr),
        .data_idx_i    (data_idx),
        .data_i        (wr_data),
        .link_wr_i     (link_wr),
        .link_idx_i    (link_idx),
        .link_next_i   (link_next),
        .release_i     (release_en),
        .release_idx_i (release_idx),
        .data_vec_o    (data_vec),
        .free_vec_o    (free_vec)
    );

    id_queue_exists_search u_exists_search (
        .data_vec_i    (data_vec),
        .free_vec_i    (free_vec),
        .exists_data_i (exists_data_i),
        .exists_mask_i (exists_mask_i),
        .exists_req_i  (exists_req_i),
        .exists_o      (exists_o),
        .exists_gnt_o  (exists_gnt_o)
    );

endmodule

//--- testbench/id_queue_sva.sv
// Concurrent checks on the ID queue grants and the output valid flag
`timescale 1ns/100ps

module id_queue_sva (
    input logic clk_i,
    input logic rst_ni,
    input logic inp_req_i,
    input logic inp_gnt_i,
    input logic oup_req_i,
    input logic oup_gnt_i,
    input logic oup_data_valid_i,
    input logic exists_req_i,
    input logic exists_gnt_i
);

    // A granted push owns the cycle, so both ports are never granted together
    push_blocks_output: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (inp_req_i && oup_req_i && inp_gnt_i) |-> !oup_gnt_i
    ) else $error("output port granted in a cycle with a granted push");

    // Valid data is only shown on a granted output request
    valid_needs_grant: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        oup_data_valid_i |-> oup_gnt_i
    ) else $error("output data valid without an output grant");

    // The exists search never stalls
    exists_grant_follows: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        exists_gnt_i == exists_req_i
    ) else $error("exists grant differs from exists request");

endmodule

bind id_queue_top id_queue_sva u_sva (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .inp_req_i        (inp_req_i),
    .inp_gnt_i        (inp_gnt_o),
    .oup_req_i        (oup_req_i),
    .oup_gnt_i        (oup_gnt_o),
    .oup_data_valid_i (oup_data_valid_o),
    .exists_req_i     (exists_req_i),
    .exists_gnt_i     (exists_gnt_o)
);

//--- testbench/tb_id_queue.sv
// Testbench for the ID queue driving random traffic and checking it against per-ID FIFO models
`timescale 1ns/100ps

module tb_id_queue
    import id_queue_cfg_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 5;
    localparam int N_CYCLES     = 2000;
    localparam int PHASE_LEN    = 200;
    localparam int N_PHASES     = 5;
    // Twice the nominal run length, reset included
    localparam int WATCHDOG_NS  = (N_CYCLES + RESET_CYCLES) * CLK_PERIOD * 2;

    // Request densities in percent per phase
    // Phase 0 only pushes so the queue fills up and the input grant drops
    // Phase 3 only reads and pops, which drains the queue and then hits empty IDs
    localparam int PUSH_PCT [N_PHASES] = '{100, 30, 60, 0, 45};
    localparam int OUP_PCT  [N_PHASES] = '{0, 80, 50, 90, 60};
    localparam int POP_PCT  [N_PHASES] = '{0, 70, 50, 80, 30};

    logic  clk_i;
    logic  rst_ni;
    logic  inp_req_i;
    id_t   inp_id_i;
    data_t inp_data_i;
    logic  inp_gnt_o;
    logic  oup_req_i;
    id_t   oup_id_i;
    logic  oup_pop_i;
    logic  oup_gnt_o;
    data_t oup_data_o;
    logic  oup_data_valid_o;
    logic  exists_req_i;
    data_t exists_data_i;
    data_t exists_mask_i;
    logic  exists_o;
    logic  exists_gnt_o;

    // Reference model: one FIFO per ID plus the total element count
    data_t fifo_q [N_IDS][$];
    int    total_count;

    int    seed;
    int    errors;
    int    checks;
    // Set when a push request was refused, so the same push is offered again
    logic  push_stalled;

    id_queue_top DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Uniform number in 0..99 from the seeded generator
    function automatic int rand_pct();
        return int'($unsigned($random(seed)) % 100);
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error: %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_word(input string name, input data_t expected, input data_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("error: %s expected %h got %h at %0t", name, expected, actual, $time);
        end
    endtask

    // True when any stored element agrees with the word on every masked bit
    function automatic logic model_exists(input data_t word, input data_t mask);
        logic found;
        found = 1'b0;
        for (int id = 0; id < N_IDS; id++) begin
            for (int j = 0; j < fifo_q[id].size(); j++) begin
                if ((fifo_q[id][j] & mask) == (word & mask)) begin
                    found = 1'b1;
                end
            end
        end
        return found;
    endfunction

    task automatic drive_random(input int cycle);
        int phase;
        int sel;
        phase = (cycle / PHASE_LEN) % N_PHASES;
        // A refused push keeps its request, ID and data until the queue takes it
        if (!push_stalled) begin
            inp_req_i  <= rand_pct() < PUSH_PCT[phase];
            inp_id_i   <= id_t'($random(seed));
            inp_data_i <= data_t'($random(seed));
        end
        oup_req_i     <= rand_pct() < OUP_PCT[phase];
        oup_id_i      <= id_t'($random(seed));
        oup_pop_i     <= rand_pct() < POP_PCT[phase];
        exists_req_i  <= rand_pct() < 70;
        exists_data_i <= data_t'($random(seed));
        // Mostly sparse masks so that some searches hit and some miss
        sel = rand_pct();
        if (sel < 15) begin
            exists_mask_i <= '0;
        end else if (sel < 30) begin
            exists_mask_i <= '1;
        end else begin
            exists_mask_i <= data_t'($random(seed) & $random(seed) & $random(seed));
        end
    endtask

    // Outputs are stable here, half a cycle after the inputs changed
    task automatic check_and_update();
        logic  exp_push;
        logic  exp_valid;
        data_t exp_data;
        exp_push  = inp_req_i && (total_count < CAPACITY);
        exp_valid = 1'b0;
        exp_data  = '0;
        check_bit("inp_gnt_o", total_count < CAPACITY, inp_gnt_o);
        // Any accepted push starves the output port for the cycle
        check_bit("oup_gnt_o", oup_req_i && !exp_push, oup_gnt_o);
        check_bit("exists_gnt_o", exists_req_i, exists_gnt_o);
        check_bit("exists_o", exists_req_i && model_exists(exists_data_i, exists_mask_i),
                  exists_o);
        if (oup_req_i && !exp_push) begin
            if (fifo_q[oup_id_i].size() > 0) begin
                exp_valid = 1'b1;
                exp_data  = fifo_q[oup_id_i][0];
            end
            // A miss must come back as zero data
            check_word("oup_data_o", exp_data, oup_data_o);
        end
        check_bit("oup_data_valid_o", exp_valid, oup_data_valid_o);
        // Apply what the coming rising edge commits
        if (exp_push) begin
            fifo_q[inp_id_i].push_back(inp_data_i);
            total_count++;
        end else if (oup_pop_i && exp_valid) begin
            void'(fifo_q[oup_id_i].pop_front());
            total_count--;
        end
        push_stalled = inp_req_i && !exp_push;
    endtask

    initial begin
        seed          = 36124;
        errors        = 0;
        checks        = 0;
        total_count   = 0;
        push_stalled  = 1'b0;
        rst_ni        = 1'b0;
        inp_req_i     = 1'b0;
        inp_id_i      = '0;
        inp_data_i    = '0;
        oup_req_i     = 1'b0;
        oup_id_i      = '0;
        oup_pop_i     = 1'b0;
        exists_req_i  = 1'b0;
        exists_data_i = '0;
        exists_mask_i = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        // With no request present this checks the idle state after reset
        @(negedge clk_i);
        check_and_update();
        for (int cycle = 0; cycle < N_CYCLES; cycle++) begin
            @(posedge clk_i);
            drive_random(cycle);
            @(negedge clk_i);
            check_and_update();
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Stops a run that gets stuck
    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the stimulus finished", WATCHDOG_NS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- filelist.f
design/id_queue_cfg_pkg.sv
design/id_queue_entry_pkg.sv
design/id_queue_free_search.sv
design/id_queue_ht_table.sv
design/id_queue_ld_table.sv
design/id_queue_exists_search.sv
design/id_queue_ctrl.sv
design/id_queue_top.sv
testbench/id_queue_sva.sv
testbench/tb_id_queue.sv

//--- Makefile
# Verilator build, run and lint for the ID queue testbench

VERILATOR  ?= verilator
TOP        := tb_id_queue
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing --assert
PASS_MSG   := TB PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only if the pass line shows up in the simulation output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
